//--- hdl/id_remap_pkg.sv
package id_remap_pkg;

  // ID widths on the upstream and downstream side
  localparam int unsigned ID_IN_WIDTH  = 6;
  localparam int unsigned ID_OUT_WIDTH = 3;

  // Output IDs in use per direction, also the burst limit per output ID
  localparam int unsigned TABLE_SIZE = 4;
  localparam int unsigned IDX_WIDTH  = $clog2(TABLE_SIZE);
  localparam int unsigned CNT_WIDTH  = $clog2(TABLE_SIZE + 1);

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned LEN_WIDTH  = 8;

  typedef logic [ID_IN_WIDTH-1:0]  id_in_t;
  typedef logic [ID_OUT_WIDTH-1:0] id_out_t;
  typedef logic [IDX_WIDTH-1:0]    idx_t;
  typedef logic [CNT_WIDTH-1:0]    cnt_t;
  typedef logic [1:0]              resp_t;

  // Write request carries only the address
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
  } aw_payload_t;

  // Read request carries the address and the burst length
  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]  len;
  } ar_payload_t;

endpackage

//--- hdl/id_remap_table.sv
module id_remap_table (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  input  logic                 push_i,
  input  id_remap_pkg::id_in_t push_id_i,
  input  id_remap_pkg::idx_t   push_idx_i,

  input  id_remap_pkg::id_in_t lookup_id_i,
  output logic                 alloc_ok_o,
  output id_remap_pkg::idx_t   alloc_idx_o,

  input  logic                 pop_i,
  input  id_remap_pkg::idx_t   pop_idx_i,
  output id_remap_pkg::id_in_t pop_id_o
);
  import id_remap_pkg::*;

  // One entry per output index: the input ID it serves and its in-flight count
  id_in_t id_q  [TABLE_SIZE];
  cnt_t   cnt_q [TABLE_SIZE];
  cnt_t   cnt_d [TABLE_SIZE];

  logic [TABLE_SIZE-1:0] free;
  logic [TABLE_SIZE-1:0] match;
  logic                  free_any;
  logic                  match_any;
  idx_t                  free_idx;
  idx_t                  match_idx;

  // An entry with a zero count is free, an occupied entry can match the lookup ID
  always_comb begin
    for (int i = 0; i < TABLE_SIZE; i++) begin
      free[i]  = (cnt_q[i] == '0);
      match[i] = !free[i] && (id_q[i] == lookup_id_i);
    end
  end

  // Priority encoders, scanning downwards so the lowest set index wins
  always_comb begin
    free_any  = 1'b0;
    free_idx  = '0;
    match_any = 1'b0;
    match_idx = '0;
    for (int i = TABLE_SIZE - 1; i >= 0; i--) begin
      if (free[i]) begin
        free_any = 1'b1;
        free_idx = idx_t'(i);
      end
      if (match[i]) begin
        match_any = 1'b1;
        match_idx = idx_t'(i);
      end
    end
  end

  // A matching input ID must reuse its index to keep ordering, unless that
  // entry has saturated; otherwise take the lowest free index
  assign alloc_ok_o  = match_any ? (cnt_q[match_idx] < cnt_t'(TABLE_SIZE)) : free_any;
  assign alloc_idx_o = match_any ? match_idx : free_idx;

  // Restore the original input ID of a returning response
  assign pop_id_o = id_q[pop_idx_i];

  // Push and pop on the same entry in one cycle leave its count unchanged
  always_comb begin
    for (int i = 0; i < TABLE_SIZE; i++) begin
      cnt_d[i] = cnt_q[i];
      if (push_i && (push_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] + cnt_t'(1);
      end
      if (pop_i && (pop_idx_i == idx_t'(i))) begin
        cnt_d[i] = cnt_d[i] - cnt_t'(1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < TABLE_SIZE; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Stored IDs are only meaningful while the count is nonzero
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      id_q[push_idx_i] <= push_id_i;
    end
  end

endmodule

//--- hdl/ax_remap_issue.sv
module ax_remap_issue #(
  parameter type payload_t = logic
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  id_remap_pkg::id_in_t  in_id_i,
  input  payload_t              in_payload_i,

  output logic                  out_valid_o,
  input  logic                  out_ready_i,
  output id_remap_pkg::id_out_t out_id_o,
  output payload_t              out_payload_o,

  input  logic                  alloc_ok_i,
  input  id_remap_pkg::idx_t    alloc_idx_i,
  output logic                  push_o,
  output id_remap_pkg::idx_t    push_idx_o
);
  import id_remap_pkg::*;

  typedef enum logic {
    Ready,
    Hold
  } state_e;

  state_e state_d, state_q;
  idx_t   idx_d, idx_q;
  idx_t   out_idx;

  always_comb begin
    state_d     = state_q;
    idx_d       = idx_q;
    out_valid_o = 1'b0;
    in_ready_o  = 1'b0;
    push_o      = 1'b0;
    out_idx     = alloc_idx_i;

    unique case (state_q)
      Ready: begin
        // Forward in the same cycle as the table accepts the burst
        if (in_valid_i && alloc_ok_i) begin
          out_valid_o = 1'b1;
          push_o      = 1'b1;
          in_ready_o  = out_ready_i;
          if (!out_ready_i) begin
            idx_d   = alloc_idx_i;
            state_d = Hold;
          end
        end
      end
      Hold: begin
        // The entry is already pushed, keep presenting the same index
        out_idx     = idx_q;
        out_valid_o = 1'b1;
        in_ready_o  = out_ready_i;
        if (out_ready_i) begin
          state_d = Ready;
        end
      end
      default: state_d = Ready;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Ready;
      idx_q   <= '0;
    end else begin
      state_q <= state_d;
      idx_q   <= idx_d;
    end
  end

  assign push_idx_o    = alloc_idx_i;
  assign out_id_o      = id_out_t'(out_idx);
  assign out_payload_o = in_payload_i;

endmodule

//--- hdl/id_remap_top.sv
module id_remap_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic                      s_aw_valid_i,
  output logic                      s_aw_ready_o,
  input  id_remap_pkg::id_in_t      s_aw_id_i,
  input  id_remap_pkg::aw_payload_t s_aw_payload_i,

  input  logic                      s_ar_valid_i,
  output logic                      s_ar_ready_o,
  input  id_remap_pkg::id_in_t      s_ar_id_i,
  input  id_remap_pkg::ar_payload_t s_ar_payload_i,

  output logic                      s_b_valid_o,
  input  logic                      s_b_ready_i,
  output id_remap_pkg::id_in_t      s_b_id_o,
  output id_remap_pkg::resp_t       s_b_resp_o,

  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,
  output id_remap_pkg::id_in_t      s_r_id_o,
  output id_remap_pkg::resp_t       s_r_resp_o,
  output logic                      s_r_last_o,

  output logic                      m_aw_valid_o,
  input  logic                      m_aw_ready_i,
  output id_remap_pkg::id_out_t     m_aw_id_o,
  output id_remap_pkg::aw_payload_t m_aw_payload_o,

  output logic                      m_ar_valid_o,
  input  logic                      m_ar_ready_i,
  output id_remap_pkg::id_out_t     m_ar_id_o,
  output id_remap_pkg::ar_payload_t m_ar_payload_o,

  input  logic                      m_b_valid_i,
  output logic                      m_b_ready_o,
  input  id_remap_pkg::id_out_t     m_b_id_i,
  input  id_remap_pkg::resp_t       m_b_resp_i,

  input  logic                      m_r_valid_i,
  output logic                      m_r_ready_o,
  input  id_remap_pkg::id_out_t     m_r_id_i,
  input  id_remap_pkg::resp_t       m_r_resp_i,
  input  logic                      m_r_last_i
);
  import id_remap_pkg::*;

  logic aw_alloc_ok, ar_alloc_ok;
  idx_t aw_alloc_idx, ar_alloc_idx;
  logic aw_push, ar_push;
  idx_t aw_push_idx, ar_push_idx;
  logic wr_pop, rd_pop;

  // Responses pass straight through apart from the restored ID
  assign s_b_valid_o = m_b_valid_i;
  assign m_b_ready_o = s_b_ready_i;
  assign s_b_resp_o  = m_b_resp_i;
  assign s_r_valid_o = m_r_valid_i;
  assign m_r_ready_o = s_r_ready_i;
  assign s_r_resp_o  = m_r_resp_i;
  assign s_r_last_o  = m_r_last_i;

  // A write entry frees on B, a read entry only on the last R beat
  assign wr_pop = m_b_valid_i && s_b_ready_i;
  assign rd_pop = m_r_valid_i && s_r_ready_i && m_r_last_i;

  ax_remap_issue #(
    .payload_t (aw_payload_t)
  ) i_aw_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (s_aw_valid_i),
    .in_ready_o    (s_aw_ready_o),
    .in_id_i       (s_aw_id_i),
    .in_payload_i  (s_aw_payload_i),
    .out_valid_o   (m_aw_valid_o),
    .out_ready_i   (m_aw_ready_i),
    .out_id_o      (m_aw_id_o),
    .out_payload_o (m_aw_payload_o),
    .alloc_ok_i    (aw_alloc_ok),
    .alloc_idx_i   (aw_alloc_idx),
    .push_o        (aw_push),
    .push_idx_o    (aw_push_idx)
  );

  ax_remap_issue #(
    .payload_t (ar_payload_t)
  ) i_ar_issue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .in_valid_i    (s_ar_valid_i),
    .in_ready_o    (s_ar_ready_o),
    .in_id_i       (s_ar_id_i),
    .in_payload_i  (s_ar_payload_i),
    .out_valid_o   (m_ar_valid_o),
    .out_ready_i   (m_ar_ready_i),
    .out_id_o      (m_ar_id_o),
    .out_payload_o (m_ar_payload_o),
    .alloc_ok_i    (ar_alloc_ok),
    .alloc_idx_i   (ar_alloc_idx),
    .push_o        (ar_push),
    .push_idx_o    (ar_push_idx)
  );

  id_remap_table i_wr_table (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (aw_push),
    .push_id_i   (s_aw_id_i),
    .push_idx_i  (aw_push_idx),
    .lookup_id_i (s_aw_id_i),
    .alloc_ok_o  (aw_alloc_ok),
    .alloc_idx_o (aw_alloc_idx),
    .pop_i       (wr_pop),
    .pop_idx_i   (m_b_id_i[IDX_WIDTH-1:0]),
    .pop_id_o    (s_b_id_o)
  );

  id_remap_table i_rd_table (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (ar_push),
    .push_id_i   (s_ar_id_i),
    .push_idx_i  (ar_push_idx),
    .lookup_id_i (s_ar_id_i),
    .alloc_ok_o  (ar_alloc_ok),
    .alloc_idx_o (ar_alloc_idx),
    .pop_i       (rd_pop),
    .pop_idx_i   (m_r_id_i[IDX_WIDTH-1:0]),
    .pop_id_o    (s_r_id_o)
  );

endmodule

//--- verif/id_remap_checker.sv
module id_remap_checker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      aw_valid_i,
  input  logic                      aw_ready_i,
  input  id_remap_pkg::id_out_t     aw_id_i,
  input  id_remap_pkg::aw_payload_t aw_payload_i,
  input  logic                      ar_valid_i,
  input  logic                      ar_ready_i,
  input  id_remap_pkg::id_out_t     ar_id_i,
  input  id_remap_pkg::ar_payload_t ar_payload_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import id_remap_pkg::*;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // A request under back-pressure keeps valid, ID and payload until accepted
  aw_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_id_i) && $stable(aw_payload_i))
    else begin
      $error("AW request changed while stalled");
      fail_count++;
    end

  ar_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_id_i) && $stable(ar_payload_i))
    else begin
      $error("AR request changed while stalled");
      fail_count++;
    end

  // Only TABLE_SIZE output IDs are ever handed out
  aw_id_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_id_i[ID_OUT_WIDTH-1:IDX_WIDTH] == '0)
    else begin
      $error("AW output ID out of range");
      fail_count++;
    end

  ar_id_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_id_i[ID_OUT_WIDTH-1:IDX_WIDTH] == '0)
    else begin
      $error("AR output ID out of range");
      fail_count++;
    end

endmodule

//--- verif/tb_id_remap.sv
module tb_id_remap;
  timeunit 1ns;
  timeprecision 1ps;
  import id_remap_pkg::*;

  localparam int unsigned NUM_REQ    = 400;
  localparam int unsigned MAX_CYCLES = NUM_REQ * 40;
  localparam logic [31:0] LFSR_SEED  = 32'h984e_c34b;
  localparam logic [31:0] LFSR_TAPS  = 32'hd000_0001;

  // Input IDs come from a small pool so that bursts often share an ID
  localparam id_in_t ID_POOL [8] = '{6'h03, 6'h11, 6'h2a, 6'h07, 6'h3c, 6'h15, 6'h20, 6'h0e};

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        s_aw_valid, s_aw_ready, s_ar_valid, s_ar_ready;
  id_in_t      s_aw_id, s_ar_id;
  aw_payload_t s_aw_payload, m_aw_payload;
  ar_payload_t s_ar_payload, m_ar_payload;
  logic        s_b_valid, s_b_ready, s_r_valid, s_r_ready, s_r_last;
  id_in_t      s_b_id, s_r_id;
  resp_t       s_b_resp, s_r_resp, m_b_resp, m_r_resp;
  logic        m_aw_valid, m_aw_ready, m_ar_valid, m_ar_ready;
  id_out_t     m_aw_id, m_ar_id, m_b_id, m_r_id;
  logic        m_b_valid, m_b_ready, m_r_valid, m_r_ready, m_r_last;

  // Reference model, index 0 is the write direction and 1 the read direction
  id_in_t      model_id  [2][TABLE_SIZE];
  cnt_t        model_cnt [2][TABLE_SIZE];
  logic        held      [2];
  idx_t        cur_idx   [2];
  logic        taken     [2];
  int unsigned issued    [2];
  int unsigned completed [2];

  // Downstream responder state
  int unsigned wr_pend [TABLE_SIZE];
  int unsigned rd_q    [TABLE_SIZE][$];
  logic        taken_b, taken_r, r_active;
  idx_t        r_idx;
  int unsigned r_beats;
  int unsigned cycles;
  logic [31:0] lfsr;

  id_remap_top dut0 (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .s_aw_valid_i (s_aw_valid), .s_aw_ready_o (s_aw_ready), .s_aw_id_i (s_aw_id),
    .s_aw_payload_i (s_aw_payload),
    .s_ar_valid_i (s_ar_valid), .s_ar_ready_o (s_ar_ready), .s_ar_id_i (s_ar_id),
    .s_ar_payload_i (s_ar_payload),
    .s_b_valid_o (s_b_valid), .s_b_ready_i (s_b_ready), .s_b_id_o (s_b_id),
    .s_b_resp_o (s_b_resp),
    .s_r_valid_o (s_r_valid), .s_r_ready_i (s_r_ready), .s_r_id_o (s_r_id),
    .s_r_resp_o (s_r_resp), .s_r_last_o (s_r_last),
    .m_aw_valid_o (m_aw_valid), .m_aw_ready_i (m_aw_ready), .m_aw_id_o (m_aw_id),
    .m_aw_payload_o (m_aw_payload),
    .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready), .m_ar_id_o (m_ar_id),
    .m_ar_payload_o (m_ar_payload),
    .m_b_valid_i (m_b_valid), .m_b_ready_o (m_b_ready), .m_b_id_i (m_b_id),
    .m_b_resp_i (m_b_resp),
    .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready), .m_r_id_i (m_r_id),
    .m_r_resp_i (m_r_resp), .m_r_last_i (m_r_last)
  );

  bind id_remap_top id_remap_checker i_checker (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .aw_valid_i (m_aw_valid_o), .aw_ready_i (m_aw_ready_i),
    .aw_id_i (m_aw_id_o), .aw_payload_i (m_aw_payload_o),
    .ar_valid_i (m_ar_valid_o), .ar_ready_i (m_ar_ready_i),
    .ar_id_i (m_ar_id_o), .ar_payload_i (m_ar_payload_o)
  );

  always #4 clk_i = ~clk_i;

  // Galois LFSR, one step per bit handed out
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Reuse the entry already serving this ID unless it is saturated,
  // otherwise take the lowest entry with nothing in flight
  function automatic logic predict_alloc(input int dir, input id_in_t id, output idx_t idx);
    idx = '0;
    for (int i = 0; i < TABLE_SIZE; i++) begin
      if (model_cnt[dir][i] != '0 && model_id[dir][i] == id) begin
        idx = idx_t'(i);
        return model_cnt[dir][i] < cnt_t'(TABLE_SIZE);
      end
    end
    for (int i = 0; i < TABLE_SIZE; i++) begin
      if (model_cnt[dir][i] == '0) begin
        idx = idx_t'(i);
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input string exp, input string act);
    stop_with_failure($sformatf("FAIL %s expected 0x%s actual 0x%s", name, exp, act));
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_id_in(input string name, input id_in_t exp, input id_in_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_id_out(input string name, input id_out_t exp, input id_out_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_aw(input string name, input aw_payload_t exp, input aw_payload_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_ar(input string name, input ar_payload_t exp, input ar_payload_t act);
    if (act !== exp) report_mismatch(name, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  // The table takes the entry on the first cycle a request is presented downstream
  task automatic track_request(input int dir, input logic s_valid, input logic s_ready,
                               input id_in_t s_id, input logic m_valid, input logic m_ready,
                               input id_out_t m_id);
    idx_t  idx;
    logic  ok;
    logic  exp_valid;
    string name;
    name      = (dir == 0) ? "m_aw_id_o" : "m_ar_id_o";
    ok        = predict_alloc(dir, s_id, idx);
    exp_valid = held[dir] || (s_valid && ok);
    if (!s_valid && (m_valid || s_ready)) begin
      stop_with_failure($sformatf("%s raised a request or ready with no upstream request", name));
    end
    if (s_ready !== (exp_valid && m_ready)) begin
      stop_with_failure($sformatf("Upstream ready does not follow the %s handshake", name));
    end
    if (m_valid && !held[dir]) begin
      if (!ok) stop_with_failure($sformatf("%s forwarded while the table was full", name));
      check_id_out(name, id_out_t'(idx), m_id);
      model_id[dir][idx]  = s_id;
      model_cnt[dir][idx] = model_cnt[dir][idx] + cnt_t'(1);
      cur_idx[dir]        = idx;
    end else if (m_valid) begin
      check_id_out(name, id_out_t'(cur_idx[dir]), m_id);
    end else if (held[dir] || (s_valid && ok)) begin
      stop_with_failure($sformatf("%s not presented although it was allowed", name));
    end
    held[dir] = m_valid && !m_ready;
  endtask

  task automatic drive_inputs();
    idx_t start;
    idx_t idx;
    if (!s_aw_valid || taken[0]) begin
      s_aw_valid = 1'b0;
      taken[0]   = 1'b0;
      if (issued[0] < NUM_REQ && rand_bits(1) != 0) begin
        s_aw_valid   = 1'b1;
        s_aw_id      = ID_POOL[3'(rand_bits(3))];
        s_aw_payload = aw_payload_t'(rand_bits(32));
        issued[0]++;
      end
    end
    if (!s_ar_valid || taken[1]) begin
      s_ar_valid = 1'b0;
      taken[1]   = 1'b0;
      if (issued[1] < NUM_REQ && rand_bits(1) != 0) begin
        s_ar_valid   = 1'b1;
        s_ar_id      = ID_POOL[3'(rand_bits(3))];
        s_ar_payload = ar_payload_t'({rand_bits(32), 8'(rand_bits(2))});
        issued[1]++;
      end
    end
    m_aw_ready = rand_bits(2) != 0;
    m_ar_ready = rand_bits(2) != 0;
    s_b_ready  = rand_bits(1) != 0;
    s_r_ready  = rand_bits(2) != 0;
    // Answer writes of any output ID from a random starting point
    if (!m_b_valid || taken_b) begin
      m_b_valid = 1'b0;
      taken_b   = 1'b0;
      start     = idx_t'(rand_bits(IDX_WIDTH));
      for (int i = 0; i < TABLE_SIZE; i++) begin
        idx = start + idx_t'(i);
        if (!m_b_valid && wr_pend[idx] != 0) begin
          m_b_valid = 1'b1;
          m_b_id    = id_out_t'(idx);
          m_b_resp  = resp_t'(rand_bits(2));
        end
      end
    end
    if (!m_r_valid || taken_r) begin
      m_r_valid = 1'b0;
      taken_r   = 1'b0;
      start     = idx_t'(rand_bits(IDX_WIDTH));
      for (int i = 0; i < TABLE_SIZE; i++) begin
        idx = start + idx_t'(i);
        if (!r_active && rd_q[idx].size() != 0) begin
          r_active = 1'b1;
          r_idx    = idx;
          r_beats  = rd_q[idx][0] + 1;
        end
      end
      // Random gaps between beats of a burst
      if (r_active && rand_bits(1) != 0) begin
        m_r_valid = 1'b1;
        m_r_id    = id_out_t'(r_idx);
        m_r_resp  = resp_t'(rand_bits(2));
        m_r_last  = (r_beats == 1);
      end
    end
  endtask

  task automatic observe_edge();
    idx_t idx;
    track_request(0, s_aw_valid, s_aw_ready, s_aw_id, m_aw_valid, m_aw_ready, m_aw_id);
    track_request(1, s_ar_valid, s_ar_ready, s_ar_id, m_ar_valid, m_ar_ready, m_ar_id);
    // Response handshakes and codes pass straight through in the same cycle
    check_flag("s_b_valid_o", m_b_valid, s_b_valid);
    check_flag("m_b_ready_o", s_b_ready, m_b_ready);
    check_resp("s_b_resp_o", m_b_resp, s_b_resp);
    check_flag("s_r_valid_o", m_r_valid, s_r_valid);
    check_flag("m_r_ready_o", s_r_ready, m_r_ready);
    check_resp("s_r_resp_o", m_r_resp, s_r_resp);
    check_flag("s_r_last_o", m_r_last, s_r_last);
    if (m_aw_valid && m_aw_ready) begin
      check_aw("m_aw_payload_o", s_aw_payload, m_aw_payload);
      wr_pend[cur_idx[0]]++;
      taken[0] = 1'b1;
    end
    if (m_ar_valid && m_ar_ready) begin
      check_ar("m_ar_payload_o", s_ar_payload, m_ar_payload);
      rd_q[cur_idx[1]].push_back(int'(s_ar_payload.len));
      taken[1] = 1'b1;
    end
    if (m_b_valid && s_b_ready) begin
      idx = idx_t'(m_b_id);
      check_id_in("s_b_id_o", model_id[0][idx], s_b_id);
      model_cnt[0][idx] = model_cnt[0][idx] - cnt_t'(1);
      wr_pend[idx]--;
      completed[0]++;
      taken_b = 1'b1;
    end
    if (m_r_valid && s_r_ready) begin
      check_id_in("s_r_id_o", model_id[1][r_idx], s_r_id);
      r_beats--;
      taken_r = 1'b1;
      // A read entry is only released by the last beat
      if (m_r_last) begin
        model_cnt[1][r_idx] = model_cnt[1][r_idx] - cnt_t'(1);
        void'(rd_q[r_idx].pop_front());
        r_active = 1'b0;
        completed[1]++;
      end
    end
  endtask

  initial begin
    lfsr         = LFSR_SEED;
    rst_ni       = 1'b0;
    s_aw_valid   = 1'b0;
    s_aw_id      = '0;
    s_aw_payload = '0;
    s_ar_valid   = 1'b0;
    s_ar_id      = '0;
    s_ar_payload = '0;
    s_b_ready    = 1'b0;
    s_r_ready    = 1'b0;
    m_aw_ready   = 1'b0;
    m_ar_ready   = 1'b0;
    m_b_valid    = 1'b0;
    m_b_id       = '0;
    m_b_resp     = '0;
    m_r_valid    = 1'b0;
    m_r_id       = '0;
    m_r_resp     = '0;
    m_r_last     = 1'b0;
    taken_b      = 1'b0;
    taken_r      = 1'b0;
    r_active     = 1'b0;
    r_idx        = '0;
    r_beats      = 0;
    cycles       = 0;
    for (int d = 0; d < 2; d++) begin
      held[d]      = 1'b0;
      cur_idx[d]   = '0;
      taken[d]     = 1'b0;
      issued[d]    = 0;
      completed[d] = 0;
      for (int i = 0; i < TABLE_SIZE; i++) begin
        model_id[d][i]  = '0;
        model_cnt[d][i] = '0;
      end
    end
    for (int i = 0; i < TABLE_SIZE; i++) wr_pend[i] = 0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    while (completed[0] < NUM_REQ || completed[1] < NUM_REQ) begin
      @(negedge clk_i);
      drive_inputs();
      @(posedge clk_i);
      observe_edge();
      cycles++;
      if (dut0.i_checker.fail_count != 0) begin
        stop_with_failure("A bound assertion on the downstream requests failed");
      end
      if (cycles >= MAX_CYCLES) begin
        stop_with_failure($sformatf("Timeout after %0d cycles with %0d writes and %0d reads done",
                                    cycles, completed[0], completed[1]));
      end
    end
    @(negedge clk_i);
    if (dut0.i_checker.fail_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      stop_with_failure("A bound assertion failed on the last cycle");
    end
  end

endmodule

//--- filelist.f
hdl/id_remap_pkg.sv
hdl/id_remap_table.sv
hdl/ax_remap_issue.sv
hdl/id_remap_top.sv
verif/id_remap_checker.sv
verif/tb_id_remap.sv

//--- Bender.yml
package:
  name: id_remap

sources:
  # RTL
  - files:
      - hdl/id_remap_pkg.sv
      - hdl/id_remap_table.sv
      - hdl/ax_remap_issue.sv
      - hdl/id_remap_top.sv

  # Testbench
  - target: test
    files:
      - verif/id_remap_checker.sv
      - verif/tb_id_remap.sv
